// File: design/id_pkg.sv
package id_pkg;

    localparam int XLEN    = 64;
    localparam int ILEN    = 32;
    localparam int REG_AW  = 5;
    localparam int SHAMT_W = 6; // rv64 shift amount

    // major opcodes
    localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OPC_OP        = 7'b0110011;
    localparam logic [6:0] OPC_OP_32     = 7'b0111011;
    localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
    localparam logic [6:0] OPC_LOAD      = 7'b0000011;
    localparam logic [6:0] OPC_STORE     = 7'b0100011;
    localparam logic [6:0] OPC_JAL       = 7'b1101111;
    localparam logic [6:0] OPC_JALR      = 7'b1100111;
    localparam logic [6:0] OPC_LUI       = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

    // alu func3
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_SR   = 3'b101;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LD  = 3'b011;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_LWU = 3'b110;

    localparam logic [2:0] F3_SB = 3'b000;
    localparam logic [2:0] F3_SH = 3'b001;
    localparam logic [2:0] F3_SW = 3'b010;
    localparam logic [2:0] F3_SD = 3'b011;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000; // sra
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    localparam int SEL_W = 3;

    localparam logic [SEL_W-1:0] OP1_ZERO = 3'd0;
    localparam logic [SEL_W-1:0] OP1_RS1  = 3'd1;
    localparam logic [SEL_W-1:0] OP1_PC   = 3'd2;

    localparam logic [SEL_W-1:0] OP2_ZERO      = 3'd0;
    localparam logic [SEL_W-1:0] OP2_RS2       = 3'd1;
    localparam logic [SEL_W-1:0] OP2_RS2_SHAMT = 3'd2;
    localparam logic [SEL_W-1:0] OP2_IMM_I     = 3'd3;
    localparam logic [SEL_W-1:0] OP2_SHAMT     = 3'd4;
    localparam logic [SEL_W-1:0] OP2_IMM_U     = 3'd5;
    localparam logic [SEL_W-1:0] OP2_FOUR      = 3'd6;

    localparam logic [SEL_W-1:0] BASE_ZERO = 3'd0;
    localparam logic [SEL_W-1:0] BASE_PC   = 3'd1;
    localparam logic [SEL_W-1:0] BASE_RS1  = 3'd2;

    localparam logic [SEL_W-1:0] OFS_ZERO  = 3'd0;
    localparam logic [SEL_W-1:0] OFS_IMM_I = 3'd1;
    localparam logic [SEL_W-1:0] OFS_IMM_S = 3'd2;
    localparam logic [SEL_W-1:0] OFS_IMM_B = 3'd3;
    localparam logic [SEL_W-1:0] OFS_IMM_J = 3'd4;
    localparam logic [SEL_W-1:0] OFS_IMM_U = 3'd5;

    // one instruction word, four field layouts
    typedef union packed {
        struct packed {
            logic [6:0] func7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] func3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  func3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] func3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic [19:0] imm20;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } inst_u;

endpackage

// File: design/id_inst_buffer.sv
`timescale 1ns/1ps

module id_inst_buffer
    import id_pkg::*;
(
    input  logic            clk,
    input  logic            reset_i,
    input  logic            in_valid_i,
    input  logic [ILEN-1:0] inst_i,
    input  logic [XLEN-1:0] inst_addr_i,
    input  logic            take_i,      // output stage can take the entry
    output logic            in_ready_o,
    output logic            buf_valid_o,
    output logic [ILEN-1:0] buf_inst_o,
    output logic [XLEN-1:0] buf_pc_o
);

    logic in_fire;

    // free slot, or the held word leaves this cycle
    assign in_ready_o = !buf_valid_o || take_i;
    assign in_fire    = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            buf_valid_o <= 1'b0;
        end else if (in_fire) begin
            buf_valid_o <= 1'b1;
        end else if (take_i) begin
            buf_valid_o <= 1'b0;  // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            buf_inst_o <= inst_i;
            buf_pc_o   <= inst_addr_i;
        end
    end

endmodule

// File: design/id_decoder.sv
`timescale 1ns/1ps

module id_decoder
    import id_pkg::*;
(
    input  inst_u             buf_inst_i,
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    output logic [REG_AW-1:0] rd_addr_o,
    output logic              reg_wen_o,
    output logic [SEL_W-1:0]  op1_sel_o,
    output logic [SEL_W-1:0]  op2_sel_o,
    output logic [SEL_W-1:0]  base_sel_o,
    output logic [SEL_W-1:0]  ofs_sel_o
);

    logic [6:0] opcode;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       use_rs1;
    logic       use_rs2;
    logic       is_shift;

    assign opcode   = buf_inst_i.r_fmt.opcode;
    assign f3       = buf_inst_i.r_fmt.func3;
    assign f7       = buf_inst_i.r_fmt.func7;
    assign is_shift = (f3 == F3_SLL) || (f3 == F3_SR);

    always_comb begin
        // anything not matched below stays an all-zero bundle
        reg_wen_o  = 1'b0;
        op1_sel_o  = OP1_ZERO;
        op2_sel_o  = OP2_ZERO;
        base_sel_o = BASE_ZERO;
        ofs_sel_o  = OFS_ZERO;
        case (opcode)
            OPC_OP_IMM: begin
                reg_wen_o = 1'b1;
                op1_sel_o = OP1_RS1;
                op2_sel_o = is_shift ? OP2_SHAMT : OP2_IMM_I;
            end
            OPC_OP_IMM_32: begin
                if (f3 == F3_ADD || is_shift) begin
                    reg_wen_o = 1'b1;
                    op1_sel_o = OP1_RS1;
                    op2_sel_o = is_shift ? OP2_SHAMT : OP2_IMM_I;
                end
            end
            OPC_OP: begin
                // sr/divu share func3, func7 tells them apart
                if (f3 != F3_SR || f7 == F7_BASE || f7 == F7_ALT || f7 == F7_MULDIV) begin
                    reg_wen_o = 1'b1;
                    op1_sel_o = OP1_RS1;
                    if (is_shift && f7 != F7_MULDIV)
                        op2_sel_o = OP2_RS2_SHAMT;  // 6-bit shift amount
                    else
                        op2_sel_o = OP2_RS2;
                end
            end
            OPC_OP_32: begin
                if (f3 != F3_SLT && f3 != F3_SLTU) begin
                    reg_wen_o = 1'b1;
                    op1_sel_o = OP1_RS1;
                    op2_sel_o = OP2_RS2;
                end
            end
            OPC_BRANCH: begin
                if (f3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU}) begin
                    op1_sel_o  = OP1_RS1;
                    op2_sel_o  = OP2_RS2;
                    base_sel_o = BASE_PC;
                    ofs_sel_o  = OFS_IMM_B;
                end
            end
            OPC_LOAD: begin
                if (f3 inside {F3_LB, F3_LH, F3_LW, F3_LD, F3_LBU, F3_LHU, F3_LWU}) begin
                    reg_wen_o  = 1'b1;
                    op1_sel_o  = OP1_RS1;
                    op2_sel_o  = OP2_IMM_I;
                    base_sel_o = BASE_RS1;
                    ofs_sel_o  = OFS_IMM_I;
                end
            end
            OPC_STORE: begin
                if (f3 inside {F3_SB, F3_SH, F3_SW, F3_SD}) begin
                    op2_sel_o  = OP2_RS2;   // store data
                    base_sel_o = BASE_RS1;
                    ofs_sel_o  = OFS_IMM_S;
                end
            end
            OPC_JAL: begin
                reg_wen_o  = 1'b1;
                op1_sel_o  = OP1_PC;        // link value pc + 4
                op2_sel_o  = OP2_FOUR;
                base_sel_o = BASE_PC;
                ofs_sel_o  = OFS_IMM_J;
            end
            OPC_JALR: begin
                reg_wen_o  = 1'b1;
                op1_sel_o  = OP1_PC;
                op2_sel_o  = OP2_FOUR;
                base_sel_o = BASE_RS1;
                ofs_sel_o  = OFS_IMM_I;
            end
            OPC_LUI: begin
                reg_wen_o = 1'b1;
                op2_sel_o = OP2_IMM_U;
            end
            OPC_AUIPC: begin
                reg_wen_o = 1'b1;
                op1_sel_o = OP1_PC;
                op2_sel_o = OP2_IMM_U;
                ofs_sel_o = OFS_IMM_U;
            end
            default: ;
        endcase
    end

    // register use follows from the chosen sources
    assign use_rs1 = (op1_sel_o == OP1_RS1) || (base_sel_o == BASE_RS1);
    assign use_rs2 = (op2_sel_o == OP2_RS2) || (op2_sel_o == OP2_RS2_SHAMT);

    assign rs1_addr_o = use_rs1 ? buf_inst_i.r_fmt.rs1 : '0;
    assign rs2_addr_o = use_rs2 ? buf_inst_i.r_fmt.rs2 : '0;
    assign rd_addr_o  = reg_wen_o ? buf_inst_i.r_fmt.rd : '0;

endmodule

// File: design/id_imm_gen.sv
`timescale 1ns/1ps

module id_imm_gen
    import id_pkg::*;
(
    input  inst_u              buf_inst_i,
    output logic [XLEN-1:0]    imm_i_o,
    output logic [XLEN-1:0]    imm_s_o,
    output logic [XLEN-1:0]    imm_b_o,
    output logic [XLEN-1:0]    imm_u_o,
    output logic [XLEN-1:0]    imm_j_o,
    output logic [SHAMT_W-1:0] shamt_o
);

    logic [11:0] s12;
    logic [19:0] u20;

    assign s12 = {buf_inst_i.s_fmt.imm_hi, buf_inst_i.s_fmt.imm_lo};
    assign u20 = buf_inst_i.u_fmt.imm20;

    assign imm_i_o = {{(XLEN-12){buf_inst_i.i_fmt.imm12[11]}}, buf_inst_i.i_fmt.imm12};
    assign imm_s_o = {{(XLEN-12){s12[11]}}, s12};

    // b type reuses the s split, bit 0 always zero
    assign imm_b_o = {{(XLEN-13){s12[11]}}, s12[11], s12[0], s12[10:1], 1'b0};
    assign imm_u_o = {{(XLEN-32){u20[19]}}, u20, 12'b0};
    assign imm_j_o = {{(XLEN-21){u20[19]}}, u20[19], u20[7:0], u20[8], u20[18:9], 1'b0};

    assign shamt_o = {buf_inst_i.r_fmt.func7[0], buf_inst_i.r_fmt.rs2}; // bit 25 is shamt[5]

endmodule

// File: design/id_operand_mux.sv
`timescale 1ns/1ps

module id_operand_mux
    import id_pkg::*;
(
    input  logic [SEL_W-1:0]   op1_sel_i,
    input  logic [SEL_W-1:0]   op2_sel_i,
    input  logic [SEL_W-1:0]   base_sel_i,
    input  logic [SEL_W-1:0]   ofs_sel_i,
    input  logic [XLEN-1:0]    rs1_data_i,
    input  logic [XLEN-1:0]    rs2_data_i,
    input  logic [XLEN-1:0]    pc_i,
    input  logic [XLEN-1:0]    imm_i_i,
    input  logic [XLEN-1:0]    imm_s_i,
    input  logic [XLEN-1:0]    imm_b_i,
    input  logic [XLEN-1:0]    imm_u_i,
    input  logic [XLEN-1:0]    imm_j_i,
    input  logic [SHAMT_W-1:0] shamt_i,
    output logic [XLEN-1:0]    op1_o,
    output logic [XLEN-1:0]    op2_o,
    output logic [XLEN-1:0]    base_addr_o,
    output logic [XLEN-1:0]    offset_addr_o
);

    always_comb begin
        case (op1_sel_i)
            OP1_RS1: op1_o = rs1_data_i;
            OP1_PC:  op1_o = pc_i;
            default: op1_o = '0;
        endcase

        case (op2_sel_i)
            OP2_RS2:       op2_o = rs2_data_i;
            OP2_RS2_SHAMT: op2_o = {{(XLEN-SHAMT_W){1'b0}}, rs2_data_i[SHAMT_W-1:0]};
            OP2_IMM_I:     op2_o = imm_i_i;
            OP2_SHAMT:     op2_o = {{(XLEN-SHAMT_W){1'b0}}, shamt_i};
            OP2_IMM_U:     op2_o = imm_u_i;
            OP2_FOUR:      op2_o = XLEN'(4);  // return address step
            default:       op2_o = '0;
        endcase

        case (base_sel_i)
            BASE_PC:  base_addr_o = pc_i;
            BASE_RS1: base_addr_o = rs1_data_i;
            default:  base_addr_o = '0;
        endcase

        case (ofs_sel_i)
            OFS_IMM_I: offset_addr_o = imm_i_i;
            OFS_IMM_S: offset_addr_o = imm_s_i;
            OFS_IMM_B: offset_addr_o = imm_b_i;
            OFS_IMM_J: offset_addr_o = imm_j_i;
            OFS_IMM_U: offset_addr_o = imm_u_i;
            default:   offset_addr_o = '0;
        endcase
    end

endmodule

// File: design/id_out_reg.sv
`timescale 1ns/1ps

module id_out_reg
    import id_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic              buf_valid_i,
    input  logic              out_ready_i,
    input  logic [ILEN-1:0]   inst_i,
    input  logic [XLEN-1:0]   pc_i,
    input  logic [XLEN-1:0]   op1_i,
    input  logic [XLEN-1:0]   op2_i,
    input  logic [REG_AW-1:0] rd_addr_i,
    input  logic              reg_wen_i,
    input  logic [XLEN-1:0]   base_addr_i,
    input  logic [XLEN-1:0]   offset_addr_i,
    output logic              take_o,
    output logic              out_valid_o,
    output logic [ILEN-1:0]   inst_o,
    output logic [XLEN-1:0]   pc_o,
    output logic [XLEN-1:0]   op1_o,
    output logic [XLEN-1:0]   op2_o,
    output logic [REG_AW-1:0] rd_addr_o,
    output logic              reg_wen_o,
    output logic [XLEN-1:0]   base_addr_o,
    output logic [XLEN-1:0]   offset_addr_o
);

    logic load;

    // empty, or the current bundle is leaving
    assign take_o = !out_valid_o || out_ready_i;
    assign load   = take_o && buf_valid_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            out_valid_o <= 1'b0;
            reg_wen_o   <= 1'b0;
        end else begin
            if (take_o)
                out_valid_o <= buf_valid_i;
            if (load)
                reg_wen_o <= reg_wen_i;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            inst_o        <= inst_i;
            pc_o          <= pc_i;
            op1_o         <= op1_i;
            op2_o         <= op2_i;
            rd_addr_o     <= rd_addr_i;
            base_addr_o   <= base_addr_i;
            offset_addr_o <= offset_addr_i;
        end
    end

endmodule

// File: design/id_top.sv
`timescale 1ns/1ps

module id_top
    import id_pkg::*;
(
    input  logic              clk,
    input  logic              reset_i,
    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [ILEN-1:0]   inst_i,
    input  logic [XLEN-1:0]   inst_addr_i,
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    output logic              out_valid_o,
    input  logic              out_ready_i,
    output logic [ILEN-1:0]   inst_o,
    output logic [XLEN-1:0]   pc_o,
    output logic [XLEN-1:0]   op1_o,
    output logic [XLEN-1:0]   op2_o,
    output logic [REG_AW-1:0] rd_addr_o,
    output logic              reg_wen_o,
    output logic [XLEN-1:0]   base_addr_o,
    output logic [XLEN-1:0]   offset_addr_o
);

    logic              buf_valid;
    logic [ILEN-1:0]   buf_inst;
    logic [XLEN-1:0]   buf_pc;
    logic              out_ready_to_buf;
    logic [REG_AW-1:0] rd_addr;
    logic              reg_wen;
    logic [SEL_W-1:0]  op1_sel;
    logic [SEL_W-1:0]  op2_sel;
    logic [SEL_W-1:0]  base_sel;
    logic [SEL_W-1:0]  ofs_sel;
    logic [XLEN-1:0]   imm_i;
    logic [XLEN-1:0]   imm_s;
    logic [XLEN-1:0]   imm_b;
    logic [XLEN-1:0]   imm_u;
    logic [XLEN-1:0]   imm_j;
    logic [SHAMT_W-1:0] shamt;
    logic [XLEN-1:0]   op1;
    logic [XLEN-1:0]   op2;
    logic [XLEN-1:0]   base_addr;
    logic [XLEN-1:0]   offset_addr;

    id_inst_buffer id_inst_buffer_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .in_valid_i  (in_valid_i),
        .inst_i      (inst_i),
        .inst_addr_i (inst_addr_i),
        .take_i      (out_ready_to_buf),
        .in_ready_o  (in_ready_o),
        .buf_valid_o (buf_valid),
        .buf_inst_o  (buf_inst),
        .buf_pc_o    (buf_pc)
    );

    // register file read addresses go straight out
    id_decoder id_decoder_inst (
        .buf_inst_i (buf_inst),
        .rs1_addr_o (rs1_addr_o),
        .rs2_addr_o (rs2_addr_o),
        .rd_addr_o  (rd_addr),
        .reg_wen_o  (reg_wen),
        .op1_sel_o  (op1_sel),
        .op2_sel_o  (op2_sel),
        .base_sel_o (base_sel),
        .ofs_sel_o  (ofs_sel)
    );

    id_imm_gen id_imm_gen_inst (
        .buf_inst_i (buf_inst),
        .imm_i_o    (imm_i),
        .imm_s_o    (imm_s),
        .imm_b_o    (imm_b),
        .imm_u_o    (imm_u),
        .imm_j_o    (imm_j),
        .shamt_o    (shamt)
    );

    id_operand_mux id_operand_mux_inst (
        .op1_sel_i     (op1_sel),
        .op2_sel_i     (op2_sel),
        .base_sel_i    (base_sel),
        .ofs_sel_i     (ofs_sel),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .pc_i          (buf_pc),
        .imm_i_i       (imm_i),
        .imm_s_i       (imm_s),
        .imm_b_i       (imm_b),
        .imm_u_i       (imm_u),
        .imm_j_i       (imm_j),
        .shamt_i       (shamt),
        .op1_o         (op1),
        .op2_o         (op2),
        .base_addr_o   (base_addr),
        .offset_addr_o (offset_addr)
    );

    id_out_reg id_out_reg_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .buf_valid_i   (buf_valid),
        .out_ready_i   (out_ready_i),
        .inst_i        (buf_inst),
        .pc_i          (buf_pc),
        .op1_i         (op1),
        .op2_i         (op2),
        .rd_addr_i     (rd_addr),
        .reg_wen_i     (reg_wen),
        .base_addr_i   (base_addr),
        .offset_addr_i (offset_addr),
        .take_o        (out_ready_to_buf),
        .out_valid_o   (out_valid_o),
        .inst_o        (inst_o),
        .pc_o          (pc_o),
        .op1_o         (op1_o),
        .op2_o         (op2_o),
        .rd_addr_o     (rd_addr_o),
        .reg_wen_o     (reg_wen_o),
        .base_addr_o   (base_addr_o),
        .offset_addr_o (offset_addr_o)
    );

endmodule

// File: sim/id_sva.sv
`timescale 1ns/1ps

module id_sva
    import id_pkg::*;
(
    input logic              clk,
    input logic              reset_i,
    input logic              in_valid_i,
    input logic              in_ready_o,
    input logic              out_valid_o,
    input logic              out_ready_i,
    input logic [ILEN-1:0]   inst_o,
    input logic [XLEN-1:0]   pc_o,
    input logic [XLEN-1:0]   op1_o,
    input logic [XLEN-1:0]   op2_o,
    input logic [REG_AW-1:0] rd_addr_o,
    input logic              reg_wen_o,
    input logic [XLEN-1:0]   base_addr_o,
    input logic [XLEN-1:0]   offset_addr_o
);

    logic [ILEN+5*XLEN+REG_AW:0] bundle;
    logic [1:0]                  occupancy;  // words accepted, not yet delivered

    assign bundle = {inst_o, pc_o, op1_o, op2_o, rd_addr_o, reg_wen_o,
                     base_addr_o, offset_addr_o};

    always_ff @(posedge clk) begin
        if (reset_i)
            occupancy <= '0;
        else
            occupancy <= occupancy + 2'(in_valid_i && in_ready_o)
                                   - 2'(out_valid_o && out_ready_i);
    end

    // stalled output keeps valid up
    valid_hold: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> out_valid_o)
        else $error("out_valid_o dropped while out_ready_i was low");

    bundle_hold: assert property (@(posedge clk) disable iff (reset_i)
        out_valid_o && !out_ready_i |=> $stable(bundle))
        else $error("output bundle changed while stalled");

    // two words held and the output stalled
    full_stall: assert property (@(posedge clk) disable iff (reset_i)
        occupancy == 2'd2 && !out_ready_i |-> !in_ready_o)
        else $error("in_ready_o high with both stages full and stalled");

endmodule

// File: sim/tb_id.sv
`timescale 1ns/1ps

module tb_id
    import id_pkg::*;
();

    localparam int NUM_INST     = 400;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 5;
    localparam int DRIVE_DLY    = 2;
    localparam int TIMEOUT_NS   = (NUM_INST * 4 + RESET_CYCLES) * CLK_PERIOD;

    // one expected output transfer, plus the read addresses it needs
    typedef struct packed {
        logic [ILEN-1:0]   inst;
        logic [XLEN-1:0]   pc;
        logic [XLEN-1:0]   op1;
        logic [XLEN-1:0]   op2;
        logic [XLEN-1:0]   base;
        logic [XLEN-1:0]   ofs;
        logic [REG_AW-1:0] rd;
        logic [REG_AW-1:0] rs1a;
        logic [REG_AW-1:0] rs2a;
        logic              wen;
    } exp_t;

    logic              clk;
    logic              reset_i;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [ILEN-1:0]   inst_i;
    logic [XLEN-1:0]   inst_addr_i;
    logic [REG_AW-1:0] rs1_addr_o;
    logic [REG_AW-1:0] rs2_addr_o;
    logic [XLEN-1:0]   rs1_data_i;
    logic [XLEN-1:0]   rs2_data_i;
    logic              out_valid_o;
    logic              out_ready_i;
    logic [ILEN-1:0]   inst_o;
    logic [XLEN-1:0]   pc_o;
    logic [XLEN-1:0]   op1_o;
    logic [XLEN-1:0]   op2_o;
    logic [REG_AW-1:0] rd_addr_o;
    logic              reg_wen_o;
    logic [XLEN-1:0]   base_addr_o;
    logic [XLEN-1:0]   offset_addr_o;

    logic [XLEN-1:0] regfile [32];  // x0 stays zero
    exp_t            exp_q [$];
    integer          seed;
    int              n_checked = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    // register file answers in the same cycle
    assign rs1_data_i = regfile[rs1_addr_o];
    assign rs2_data_i = regfile[rs2_addr_o];

    id_top id_top_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .inst_i        (inst_i),
        .inst_addr_i   (inst_addr_i),
        .rs1_addr_o    (rs1_addr_o),
        .rs2_addr_o    (rs2_addr_o),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .inst_o        (inst_o),
        .pc_o          (pc_o),
        .op1_o         (op1_o),
        .op2_o         (op2_o),
        .rd_addr_o     (rd_addr_o),
        .reg_wen_o     (reg_wen_o),
        .base_addr_o   (base_addr_o),
        .offset_addr_o (offset_addr_o)
    );

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "decode stage run stopped");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        assert (got === want) else begin
            report_fail($sformatf("ERROR: %s got %h expected %h", name, got, want));
        end
    endtask

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic logic [6:0] choose_func7(input logic [1:0] s, input logic [6:0] raw);
        case (s)
            2'd0:    return 7'h00;
            2'd1:    return 7'h20;  // arithmetic shift / sub
            2'd2:    return 7'h01;  // mul/div
            default: return raw;
        endcase
    endfunction

    // random word, opcode and some fields forced per group
    function automatic logic [31:0] gen_inst();
        logic [31:0] w;
        logic [31:0] k;
        w = next_rand();
        k = next_rand();
        case (k[3:0])
            4'd0: w[6:0] = OPC_OP_IMM;
            4'd1: begin
                w[6:0] = OPC_OP_IMM_32;
                if (k[4])
                    w[14:12] = k[5] ? 3'b000 : (k[6] ? 3'b001 : 3'b101);
            end
            4'd2, 4'd3: begin
                w[6:0]   = OPC_OP;
                w[31:25] = choose_func7(k[5:4], w[31:25]);
            end
            4'd4: begin
                w[6:0]   = OPC_OP_32;
                w[31:25] = choose_func7(k[5:4], w[31:25]);
            end
            4'd5:        w[6:0] = OPC_BRANCH;
            4'd6, 4'd14: w[6:0] = OPC_LOAD;
            4'd7:        w[6:0] = OPC_STORE;
            4'd8:        w[6:0] = OPC_JAL;
            4'd9:        w[6:0] = OPC_JALR;
            4'd10:       w[6:0] = OPC_LUI;
            4'd11:       w[6:0] = OPC_AUIPC;
            4'd12:       w[6:0] = 7'b1110011;  // system, csr group
            default: ;                         // opcode as drawn
        endcase
        return w;
    endfunction

    // expected bundle straight from the rv64im encoding rules
    function automatic exp_t decode_ref(input logic [31:0] w, input logic [63:0] pc);
        exp_t        e;
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [63:0] imm_i;
        logic [63:0] imm_s;
        logic [63:0] imm_b;
        logic [63:0] imm_u;
        logic [63:0] imm_j;
        logic [63:0] rs1v;
        logic [63:0] rs2v;
        logic        shift;
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        imm_i = {{52{w[31]}}, w[31:20]};
        imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
        imm_b = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        imm_u = {{32{w[31]}}, w[31:12], 12'h000};
        imm_j = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        rs1v  = regfile[w[19:15]];
        rs2v  = regfile[w[24:20]];
        shift = (f3 == 3'b001) || (f3 == 3'b101);
        e      = '0;
        e.inst = w;
        e.pc   = pc;
        case (opc)
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                if (opc == OPC_OP_IMM || f3 == 3'b000 || shift) begin
                    e.wen  = 1'b1;
                    e.rs1a = w[19:15];
                    e.op1  = rs1v;
                    e.op2  = shift ? {58'd0, w[25:20]} : imm_i;
                end
            end
            OPC_OP: begin
                if (f3 != 3'b101 || f7 == 7'h00 || f7 == 7'h20 || f7 == 7'h01) begin
                    e.wen  = 1'b1;
                    e.rs1a = w[19:15];
                    e.rs2a = w[24:20];
                    e.op1  = rs1v;
                    e.op2  = (shift && f7 != 7'h01) ? {58'd0, rs2v[5:0]} : rs2v;
                end
            end
            OPC_OP_32: begin
                if (f3 != 3'b010 && f3 != 3'b011) begin
                    e.wen  = 1'b1;
                    e.rs1a = w[19:15];
                    e.rs2a = w[24:20];
                    e.op1  = rs1v;
                    e.op2  = rs2v;
                end
            end
            OPC_BRANCH: begin
                if (f3 != 3'b010 && f3 != 3'b011) begin
                    e.rs1a = w[19:15];
                    e.rs2a = w[24:20];
                    e.op1  = rs1v;
                    e.op2  = rs2v;
                    e.base = pc;
                    e.ofs  = imm_b;
                end
            end
            OPC_LOAD: begin
                if (f3 != 3'b111) begin
                    e.wen  = 1'b1;
                    e.rs1a = w[19:15];
                    e.op1  = rs1v;
                    e.op2  = imm_i;
                    e.base = rs1v;
                    e.ofs  = imm_i;
                end
            end
            OPC_STORE: begin
                if (!f3[2]) begin
                    e.rs1a = w[19:15];
                    e.rs2a = w[24:20];
                    e.op2  = rs2v;
                    e.base = rs1v;
                    e.ofs  = imm_s;
                end
            end
            OPC_JAL: begin
                e.wen  = 1'b1;
                e.op1  = pc;
                e.op2  = 64'd4;
                e.base = pc;
                e.ofs  = imm_j;
            end
            OPC_JALR: begin
                e.wen  = 1'b1;
                e.rs1a = w[19:15];
                e.op1  = pc;
                e.op2  = 64'd4;
                e.base = rs1v;
                e.ofs  = imm_i;
            end
            OPC_LUI: begin
                e.wen = 1'b1;
                e.op2 = imm_u;
            end
            OPC_AUIPC: begin
                e.wen = 1'b1;
                e.op1 = pc;
                e.op2 = imm_u;
                e.ofs = imm_u;
            end
            default: ;
        endcase
        if (e.wen)
            e.rd = w[11:7];
        return e;
    endfunction

    task automatic check_reset_state();
        check_value("out_valid_o", 64'(out_valid_o), 64'd0);
        check_value("in_ready_o", 64'(in_ready_o), 64'd1);
        check_value("reg_wen_o", 64'(reg_wen_o), 64'd0);
    endtask

    // word in the buffer is the oldest one not yet in the output register
    task automatic check_read_addrs();
        int idx;
        idx = out_valid_o ? 1 : 0;
        if (exp_q.size() > idx) begin
            check_value("rs1_addr_o", 64'(rs1_addr_o), 64'(exp_q[idx].rs1a));
            check_value("rs2_addr_o", 64'(rs2_addr_o), 64'(exp_q[idx].rs2a));
        end
    endtask

    task automatic compare_output();
        exp_t e;
        if (exp_q.size() == 0) begin
            report_fail("output transfer seen with no instruction outstanding");
        end else begin
            e = exp_q.pop_front();
            check_value("inst_o", 64'(inst_o), 64'(e.inst));
            check_value("pc_o", pc_o, e.pc);
            check_value("op1_o", op1_o, e.op1);
            check_value("op2_o", op2_o, e.op2);
            check_value("rd_addr_o", 64'(rd_addr_o), 64'(e.rd));
            check_value("reg_wen_o", 64'(reg_wen_o), 64'(e.wen));
            check_value("base_addr_o", base_addr_o, e.base);
            check_value("offset_addr_o", offset_addr_o, e.ofs);
            n_checked++;
        end
    endtask

    // sample mid-cycle, all handshake signals settled
    always @(negedge clk) begin
        if (!reset_i) begin
            check_read_addrs();
            if (out_valid_o && out_ready_i)
                compare_output();
            if (in_valid_i && in_ready_o)
                exp_q.push_back(decode_ref(inst_i, inst_addr_i));
        end
    end

    initial begin : main_seq
        logic [31:0] r;
        int          sent;
        int          i;
        logic        fired;
        seed        = 32'h23a7;
        clk         = 1'b0;
        reset_i     = 1'b1;
        in_valid_i  = 1'b0;
        out_ready_i = 1'b0;
        inst_i      = '0;
        inst_addr_i = '0;
        sent        = 0;
        fired       = 1'b0;
        regfile[0]  = '0;
        for (i = 1; i < 32; i++)
            regfile[i] = {next_rand(), next_rand()};

        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            check_reset_state();
        end
        reset_i = 1'b0;
        @(negedge clk);
        check_reset_state();
        @(posedge clk);
        #DRIVE_DLY;
        check_reset_state();

        while (sent < NUM_INST) begin
            if (!in_valid_i || fired) begin  // held word stays until taken
                r          = next_rand();
                in_valid_i = (r[1:0] != 2'b00);
                if (in_valid_i) begin
                    inst_i      = gen_inst();
                    inst_addr_i = {next_rand(), next_rand()} & ~64'h3;
                end
            end
            r           = next_rand();
            out_ready_i = (r[1:0] != 2'b00);
            @(negedge clk);
            fired = in_valid_i && in_ready_o;
            if (fired)
                sent++;
            @(posedge clk);
            #DRIVE_DLY;
        end
        in_valid_i = 1'b0;

        // drain with stalls still on
        while (n_checked < NUM_INST) begin
            r           = next_rand();
            out_ready_i = (r[1:0] != 2'b00);
            @(posedge clk);
            #DRIVE_DLY;
        end

        if (exp_q.size() == 0 && n_checked == NUM_INST) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            report_fail("instruction count mismatch after drain");
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        report_fail("timeout, not every instruction left the decode stage");
    end

    bind id_top id_sva id_sva_inst (
        .clk           (clk),
        .reset_i       (reset_i),
        .in_valid_i    (in_valid_i),
        .in_ready_o    (in_ready_o),
        .out_valid_o   (out_valid_o),
        .out_ready_i   (out_ready_i),
        .inst_o        (inst_o),
        .pc_o          (pc_o),
        .op1_o         (op1_o),
        .op2_o         (op2_o),
        .rd_addr_o     (rd_addr_o),
        .reg_wen_o     (reg_wen_o),
        .base_addr_o   (base_addr_o),
        .offset_addr_o (offset_addr_o)
    );

endmodule

// File: src.f
design/id_pkg.sv
design/id_inst_buffer.sv
design/id_decoder.sv
design/id_imm_gen.sv
design/id_operand_mux.sv
design/id_out_reg.sv
design/id_top.sv
sim/id_sva.sv
sim/tb_id.sv

// File: run.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module tb_id -o tb_id_sim
./obj_dir/tb_id_sim | tee sim.log

if grep -q "STATUS: PASS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
